// File: vlog.f
source/aud_fe_pkg.sv
source/sample_ram.sv
source/sbuf_arbiter.sv
source/sample_store.sv
source/frame_mover.sv
source/aud_in_fe_top.sv
test/aud_in_fe_chk.sv
test/aud_in_fe_tb.sv

// File: test/aud_in_fe_tb.sv
/* audio front end testbench
   config table, sample source, DSP bus slave model and move checks */

`timescale 1ns/1ps
`default_nettype none

module aud_in_fe_tb;

    localparam int NROWS      = 6;
    localparam int WAIT_LIMIT = 20000;
    localparam int INJ_IDX    = 5;               // sample index with bad headroom

    typedef struct packed {
        logic                           ch_mode;
        logic                           proc_ch;
        logic [aud_fe_pkg::SIZE_W-1:0]  frame_code;
        logic [aud_fe_pkg::SIZE_W-1:0]  fft_code;
        logic [aud_fe_pkg::QBITS_W-1:0] quant_bits;
        logic                           proc_en;
        logic [3:0]                     nframes;
        logic                           gnt_rand;
        logic                           inject;
    } row_t;

    // ch_mode, proc_ch, frame_code, fft_code, quant_bits, proc_en, frames, gnt_rand, inject
    row_t rows [NROWS] = '{
        '{1'b0, 1'b0, 8'd0, 8'd1, 6'd12, 1'b1, 4'd2, 1'b0, 1'b0},
        '{1'b1, 1'b1, 8'd1, 8'd3, 6'h2a, 1'b1, 4'd3, 1'b0, 1'b0},
        '{1'b0, 1'b0, 8'd0, 8'd0, 6'd5,  1'b1, 4'd1, 1'b0, 1'b1},
        '{1'b1, 1'b0, 8'd0, 8'd2, 6'd33, 1'b1, 4'd2, 1'b1, 1'b0},
        '{1'b1, 1'b1, 8'd1, 8'd1, 6'd63, 1'b1, 4'd2, 1'b1, 1'b1},
        '{1'b0, 1'b0, 8'd0, 8'd1, 6'd7,  1'b0, 4'd1, 1'b0, 1'b0}
    };

    logic                  clk;
    logic                  rst_n;
    aud_fe_pkg::aud_cfg_t  cfg;
    aud_fe_pkg::aud_pair_t aud_data;
    logic                  aud_valid;
    aud_fe_pkg::bus_req_t  bus;
    logic                  bus_gnt;
    logic                  start_proc;
    logic                  intr;
    logic                  quant_flag;

    integer                seed;
    logic                  gnt_rand = 1'b0;
    int                    errors = 0;
    int                    checks = 0;
    int                    intr_cnt = 0;
    int                    start_cnt = 0;
    int                    frame_no = 0;
    logic [15:0]           log_addr [$];     // accepted bus writes
    logic [31:0]           log_data [$];

    aud_in_fe_top aud_in_fe_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .aud_data   (aud_data),
        .aud_valid  (aud_valid),
        .bus        (bus),
        .bus_gnt    (bus_gnt),
        .start_proc (start_proc),
        .intr       (intr),
        .quant_flag (quant_flag)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // bus slave and pulse monitor
    always @(posedge clk) begin : gnt_model
        integer rnd;
        rnd = $random(seed);
        if (gnt_rand) begin
            bus_gnt <= rnd[0];
        end else begin
            bus_gnt <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (bus.req && bus_gnt) begin
                log_addr.push_back(bus.addr);
                log_data.push_back(bus.wdata);
            end
            if (intr) begin
                intr_cnt++;
            end
            if (start_proc) begin
                start_cnt++;
            end
        end
    end

    // --------------------------------------------------
    // helpers
    function automatic int frame_len(input logic [aud_fe_pkg::SIZE_W-1:0] code);
        return (int'(code) + 1) * 16;
    endfunction

    // frame*4096 + channel*1024 + index, top two bits equal
    function automatic logic [15:0] sample_value(input int fno, input int ch, input int n,
                                                 input logic inj);
        logic [15:0] v;
        v = 16'((fno * 4096 + ch * 1024 + n) & 16'h3fff);
        if (inj && (n == INJ_IDX)) begin
            v = v | 16'h8000;                    // bit 15 set, bit 14 clear
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic wait_intr(input int target);
        int cycles;
        cycles = 0;
        while ((intr_cnt < target) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            cycles++;
        end
        if (intr_cnt < target) begin
            errors++;
            $display("timeout: no frame interrupt after frame %0d", frame_no);
        end
    endtask

    task automatic wait_start(input int target);
        int cycles;
        cycles = 0;
        while ((start_cnt < target) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            cycles++;
        end
        if (start_cnt < target) begin
            errors++;
            $display("timeout: no start pulse after frame %0d", frame_no);
        end
    endtask

    task automatic apply_config(input row_t r);
        @(posedge clk);
        cfg.save_en <= 1'b0;                     // resets storer index and block
        repeat (2) @(posedge clk);
        cfg <= '{save_en: 1'b1, proc_en: r.proc_en, ch_mode: r.ch_mode,
                 proc_ch: r.proc_ch, frame_code: r.frame_code,
                 fft_code: r.fft_code, quant_bits: r.quant_bits};
        gnt_rand <= r.gnt_rand;
        repeat (2) @(posedge clk);
    endtask

    task automatic send_pair(input row_t r, input int n);
        logic [15:0] s0;
        logic [15:0] s1;
        s0 = sample_value(frame_no, 0, n, r.inject && !r.proc_ch);
        s1 = sample_value(frame_no, 1, n, r.inject && r.proc_ch);
        @(posedge clk);
        aud_data  <= {s1, s0};
        aud_valid <= 1'b1;
        @(posedge clk);
        aud_valid <= 1'b0;
        repeat (6) @(posedge clk);               // pulses 8 cycles apart
    endtask

    task automatic check_move(input row_t r, input int flen, input int fftlen);
        logic [15:0] smp;
        logic [15:0] exp_addr;
        logic [31:0] exp_word;
        checks++;
        if (log_addr.size() != fftlen) begin
            report_mismatch($sformatf("frame %0d word count", frame_no), fftlen,
                            log_addr.size());
        end
        for (int k = 0; (k < log_addr.size()) && (k < fftlen); k++) begin
            smp      = (k < flen) ? sample_value(frame_no, r.proc_ch, k, r.inject) : 16'h0;
            exp_addr = aud_fe_pkg::DSP_BUF_BASE + 16'(4 * k);
            exp_word = {10'h0, r.quant_bits, smp};
            checks += 2;
            if (log_addr[k] !== exp_addr) begin
                report_mismatch($sformatf("frame %0d word %0d addr", frame_no, k),
                                exp_addr, log_addr[k]);
            end
            if (log_data[k] !== exp_word) begin
                report_mismatch($sformatf("frame %0d word %0d data", frame_no, k),
                                exp_word, log_data[k]);
            end
        end
        checks++;
        if (quant_flag !== r.inject) begin
            report_mismatch($sformatf("frame %0d quant_flag", frame_no), r.inject, quant_flag);
        end
    endtask

    task automatic run_frame(input row_t r);
        int flen;
        int fftlen;
        int i0;
        int s0;
        flen   = frame_len(r.frame_code);
        fftlen = frame_len(r.fft_code);
        i0     = intr_cnt;
        s0     = start_cnt;
        log_addr.delete();
        log_data.delete();
        for (int n = 0; n < flen; n++) begin
            send_pair(r, n);
        end
        wait_intr(i0 + 1);
        if (r.proc_en) begin
            wait_start(s0 + 1);
            @(negedge clk);
            check_move(r, flen, fftlen);
        end else begin
            repeat (3 * flen + fftlen + 20) @(posedge clk);  // longer than a move
            @(negedge clk);
            checks += 2;
            if (log_addr.size() != 0) begin
                report_mismatch($sformatf("frame %0d writes, proc off", frame_no), 0,
                                log_addr.size());
            end
            if (start_cnt != s0) begin
                report_mismatch($sformatf("frame %0d start, proc off", frame_no), s0,
                                start_cnt);
            end
        end
        checks++;
        if (intr_cnt != i0 + 1) begin
            report_mismatch($sformatf("frame %0d intr count", frame_no), i0 + 1, intr_cnt);
        end
        frame_no++;
    endtask

    // --------------------------------------------------
    // main sequence
    initial begin
        seed      = 55063;
        rst_n     = 1'b0;
        cfg       = '0;
        aud_data  = '0;
        aud_valid = 1'b0;
        bus_gnt   = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        if ((bus.req !== 1'b0) || (start_proc !== 1'b0) || (intr !== 1'b0)
                || (quant_flag !== 1'b0)) begin
            report_mismatch("reset outputs", 32'h0,
                            {28'h0, bus.req, start_proc, intr, quant_flag});
        end
        for (int r = 0; r < NROWS; r++) begin
            apply_config(rows[r]);
            for (int f = 0; f < rows[r].nframes; f++) begin
                run_frame(rows[r]);
            end
        end
        errors += aud_in_fe_top_i.u_chk.assert_errs;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/aud_in_fe_chk.sv
/* bound assertions for the audio front end
   bus hold rule, pulse widths, arbiter grants, storer stalls */

`timescale 1ns/1ps
`default_nettype none

module aud_in_fe_chk (
    input wire logic                         clk,
    input wire logic                         rst_n,
    input wire aud_fe_pkg::bus_req_t         bus,
    input wire logic                         bus_gnt,
    input wire logic                         start_proc,
    input wire logic                         intr,
    input wire logic                         sgnt,
    input wire logic                         mgnt,
    input wire logic [aud_fe_pkg::CNT_W-1:0] stall_cnt
);

    int assert_errs = 0;                         // failed assertion count

    // pending write holds its fields until granted
    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.req && !bus_gnt) |=> (bus.req && $stable(bus.addr) && $stable(bus.wdata)))
        else begin
            $error("bus request changed before its grant");
            assert_errs++;
        end

    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        start_proc |=> !start_proc)
        else begin
            $error("start_proc high for more than one cycle");
            assert_errs++;
        end

    a_intr_pulse: assert property (@(posedge clk) disable iff (!rst_n) intr |=> !intr)
        else begin
            $error("intr high for more than one cycle");
            assert_errs++;
        end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(sgnt && mgnt))
        else begin
            $error("arbiter granted storer and mover together");
            assert_errs++;
        end

    // mover reads never come back to back
    a_single_stall: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(stall_cnt) |=> $stable(stall_cnt))
        else begin
            $error("storer lost its grant two cycles in a row");
            assert_errs++;
        end

endmodule

bind aud_in_fe_top aud_in_fe_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus),
    .bus_gnt    (bus_gnt),
    .start_proc (start_proc),
    .intr       (intr),
    .sgnt       (sgnt),
    .mgnt       (mgnt),
    .stall_cnt  (u_arb.stall_cnt)
);

`default_nettype wire

// File: source/aud_in_fe_top.sv
/* audio input front end top level
   storer, mover, buffer arbiter and sample ram */

`timescale 1ns/1ps
`default_nettype none

module aud_in_fe_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire aud_fe_pkg::aud_cfg_t    cfg,
    input  wire aud_fe_pkg::aud_pair_t   aud_data,
    input  wire logic                    aud_valid,
    output aud_fe_pkg::bus_req_t         bus,
    input  wire logic                    bus_gnt,
    output logic                         start_proc,
    output logic                         intr,
    output logic                         quant_flag
);

    // --------------------------------------------------
    // internal nets
    aud_fe_pkg::sbuf_req_t sreq;             // storer writes
    aud_fe_pkg::sbuf_req_t mreq;             // mover reads
    aud_fe_pkg::sbuf_req_t ram_req;
    logic                  sgnt;
    logic                  mgnt;
    logic [aud_fe_pkg::SAMPLE_W-1:0] rdata;
    logic                  frame_done;
    logic                  done_blk;

    sample_store u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .aud_data   (aud_data),
        .aud_valid  (aud_valid),
        .sreq       (sreq),
        .sgnt       (sgnt),
        .frame_done (frame_done),
        .done_blk   (done_blk),
        .intr       (intr)
    );

    frame_mover u_mover (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .frame_done (frame_done),
        .done_blk   (done_blk),
        .mreq       (mreq),
        .mgnt       (mgnt),
        .rdata      (rdata),
        .bus        (bus),
        .bus_gnt    (bus_gnt),
        .start_proc (start_proc),
        .quant_flag (quant_flag)
    );

    sbuf_arbiter u_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .sreq    (sreq),
        .mreq    (mreq),
        .sgnt    (sgnt),
        .mgnt    (mgnt),
        .ram_req (ram_req)
    );

    sample_ram u_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

// File: source/frame_mover.sv
/* frame mover
   reads the selected channel of a finished block, writes it to the dsp
   buffer, pads zero words to the fft size and pulses start_proc */

`timescale 1ns/1ps
`default_nettype none

module frame_mover (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire aud_fe_pkg::aud_cfg_t            cfg,
    input  wire logic                            frame_done,
    input  wire logic                            done_blk,
    output aud_fe_pkg::sbuf_req_t                mreq,
    input  wire logic                            mgnt,
    input  wire logic [aud_fe_pkg::SAMPLE_W-1:0] rdata,
    output aud_fe_pkg::bus_req_t                 bus,
    input  wire logic                            bus_gnt,
    output logic                                 start_proc,
    output logic                                 quant_flag
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE,
        ST_FILL,
        ST_DONE
    } mv_state_t;

    mv_state_t                           state;
    logic                                blk_r;      // block being moved
    logic [aud_fe_pkg::CNT_W-1:0]        cnt;        // word index
    logic [aud_fe_pkg::CNT_W-1:0]        nxt_cnt;
    logic [aud_fe_pkg::CNT_W-1:0]        frame_size;
    logic [aud_fe_pkg::CNT_W-1:0]        fft_size;
    logic                                start_move;
    logic                                rd_blk;
    logic                                last_sample;
    logic                                last_word;
    logic                                need_fill;
    logic                                bus_req_r;
    logic [aud_fe_pkg::BUS_AW-1:0]       bus_addr_r;
    logic [aud_fe_pkg::BUS_DW-1:0]       bus_wdata_r;

    // {zero, quant tag, sample}
    function automatic logic [aud_fe_pkg::BUS_DW-1:0] make_word(
        input logic [aud_fe_pkg::QBITS_W-1:0]  qbits,
        input logic [aud_fe_pkg::SAMPLE_W-1:0] s
    );
        logic [aud_fe_pkg::BUS_DW-1:0] w;
        w = '0;
        w[aud_fe_pkg::SAMPLE_W-1:0] = s;
        w[aud_fe_pkg::SAMPLE_W +: aud_fe_pkg::QBITS_W] = qbits;
        return w;
    endfunction

    function automatic logic [aud_fe_pkg::BUS_AW-1:0] word_addr(
        input logic [aud_fe_pkg::CNT_W-1:0] k
    );
        logic [aud_fe_pkg::BUS_AW-1:0] off;
        off = aud_fe_pkg::BUS_AW'(k) << 2;
        return aud_fe_pkg::DSP_BUF_BASE + off;
    endfunction

    assign frame_size  = aud_fe_pkg::code_to_size(cfg.frame_code);
    assign fft_size    = aud_fe_pkg::code_to_size(cfg.fft_code);
    assign need_fill   = (fft_size > frame_size);
    assign last_sample = (cnt == frame_size - 1'b1);
    assign last_word   = (cnt == fft_size - 1'b1);
    assign nxt_cnt     = cnt + 1'b1;
    assign start_move  = (state == ST_IDLE) && frame_done && cfg.proc_en;

    // first read goes out in the same cycle as frame_done
    assign rd_blk = (state == ST_IDLE) ? done_blk : blk_r;

    always_comb begin
        mreq.en    = start_move || (state == ST_READ);
        mreq.we    = 1'b0;
        mreq.addr  = aud_fe_pkg::sbuf_addr(rd_blk, cfg.proc_ch, cnt);
        mreq.wdata = '0;
    end

    // --------------------------------------------------
    // move FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            blk_r      <= 1'b0;
            cnt        <= '0;
            bus_req_r  <= 1'b0;
            quant_flag <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_move) begin
                        blk_r      <= done_blk;
                        cnt        <= '0;
                        quant_flag <= 1'b0;       // fresh move
                        state      <= mgnt ? ST_WAIT : ST_READ;
                    end
                end
                ST_READ: begin
                    if (mgnt) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    bus_req_r <= 1'b1;
                    state     <= ST_WRITE;
                    if (rdata[aud_fe_pkg::SAMPLE_W-1] ^ rdata[aud_fe_pkg::SAMPLE_W-2]) begin
                        quant_flag <= 1'b1;       // top bits disagree
                    end
                end
                ST_WRITE: begin
                    if (bus_gnt) begin
                        cnt <= nxt_cnt;
                        if (!last_sample) begin
                            bus_req_r <= 1'b0;
                            state     <= ST_READ;
                        end else if (need_fill) begin
                            state <= ST_FILL;     // req stays up
                        end else begin
                            bus_req_r <= 1'b0;
                            state     <= ST_DONE;
                        end
                    end
                end
                ST_FILL: begin
                    if (bus_gnt) begin
                        cnt <= nxt_cnt;
                        if (last_word) begin
                            bus_req_r <= 1'b0;
                            state     <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    cnt   <= '0;
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // bus payload, changes only outside a pending request
    always_ff @(posedge clk) begin
        if (state == ST_WAIT) begin
            bus_addr_r  <= word_addr(cnt);
            bus_wdata_r <= make_word(cfg.quant_bits, rdata);
        end else if ((state == ST_WRITE) && bus_gnt && last_sample && need_fill) begin
            bus_addr_r  <= word_addr(nxt_cnt);
            bus_wdata_r <= make_word(cfg.quant_bits, '0);
        end else if ((state == ST_FILL) && bus_gnt && !last_word) begin
            bus_addr_r  <= word_addr(nxt_cnt);
        end
    end

    always_comb begin
        bus.req   = bus_req_r;
        bus.addr  = bus_addr_r;
        bus.wdata = bus_wdata_r;
    end

    assign start_proc = (state == ST_DONE);

endmodule

`default_nettype wire

// File: source/sample_store.sv
/* sample storer
   captures input pairs and writes them into ping-pong frame blocks */

`timescale 1ns/1ps
`default_nettype none

module sample_store (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire aud_fe_pkg::aud_cfg_t    cfg,
    input  wire aud_fe_pkg::aud_pair_t   aud_data,
    input  wire logic                    aud_valid,
    output aud_fe_pkg::sbuf_req_t        sreq,
    input  wire logic                    sgnt,
    output logic                         frame_done,
    output logic                         done_blk,
    output logic                         intr
);

    // --------------------------------------------------
    // state
    aud_fe_pkg::aud_pair_t          pair_r;  // captured pair
    logic                           save_en_d;
    logic                           save_fall;
    logic                           wr_busy;  // pair being written
    logic                           wr_ch;    // channel in flight
    logic                           blk;      // block being filled
    logic [aud_fe_pkg::CNT_W-1:0]   idx;      // sample index in frame
    logic [aud_fe_pkg::CNT_W-1:0]   frame_size;
    logic                           capture;
    logic                           last_ch;
    logic                           last_idx;

    assign frame_size = aud_fe_pkg::code_to_size(cfg.frame_code);
    assign save_fall  = save_en_d && !cfg.save_en;
    assign capture    = aud_valid && cfg.save_en && !wr_busy;  // busy drops new valids
    assign last_ch    = (wr_ch == cfg.ch_mode);
    assign last_idx   = (idx == frame_size - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            save_en_d <= 1'b0;
        end else begin
            save_en_d <= cfg.save_en;
        end
    end

    // payload, loaded on accepted valid
    always_ff @(posedge clk) begin
        if (capture) begin
            pair_r <= aud_data;
        end
    end

    // --------------------------------------------------
    // write sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy    <= 1'b0;
            wr_ch      <= 1'b0;
            blk        <= 1'b0;
            idx        <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (save_fall) begin
                wr_busy <= 1'b0;
                wr_ch   <= 1'b0;
                blk     <= 1'b0;
                idx     <= '0;
            end else if (capture) begin
                wr_busy <= 1'b1;
                wr_ch   <= 1'b0;
            end else if (wr_busy && sgnt) begin
                if (last_ch) begin
                    wr_busy <= 1'b0;
                    wr_ch   <= 1'b0;
                    if (last_idx) begin
                        idx        <= '0;
                        blk        <= !blk;       // swap ping-pong block
                        frame_done <= 1'b1;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end else begin
                    wr_ch <= 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // buffer request and outputs
    always_comb begin
        sreq.en    = wr_busy;
        sreq.we    = 1'b1;
        sreq.addr  = aud_fe_pkg::sbuf_addr(blk, wr_ch, idx);
        sreq.wdata = pair_r[wr_ch];
    end

    assign done_blk = !blk;                   // block just closed
    assign intr     = frame_done;

endmodule

`default_nettype wire

// File: source/sbuf_arbiter.sv
/* sample buffer arbiter
   fixed priority to the mover, storer stall count */

`timescale 1ns/1ps
`default_nettype none

module sbuf_arbiter (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire aud_fe_pkg::sbuf_req_t sreq,
    input  wire aud_fe_pkg::sbuf_req_t mreq,
    output logic                       sgnt,
    output logic                       mgnt,
    output aud_fe_pkg::sbuf_req_t      ram_req
);

    logic [aud_fe_pkg::CNT_W-1:0] stall_cnt;   // storer lost grants

    // mover reads beat storer writes
    assign mgnt = mreq.en;
    assign sgnt = sreq.en && !mreq.en;

    always_comb begin
        if (mreq.en) begin
            ram_req = mreq;
        end else begin
            ram_req = sreq;                     // en low when idle
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_cnt <= '0;
        end else if (sreq.en && mreq.en) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/sample_ram.sv
/* single-port sample buffer, registered read */

`timescale 1ns/1ps
`default_nettype none

module sample_ram (
    input  wire logic                            clk,
    input  wire aud_fe_pkg::sbuf_req_t           ram_req,
    output logic [aud_fe_pkg::SAMPLE_W-1:0]      rdata
);

    localparam int DEPTH = 2 ** aud_fe_pkg::SBUF_AW;

    logic [aud_fe_pkg::SAMPLE_W-1:0] mem [DEPTH];

    // rdata holds until the next read
    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            if (ram_req.we) begin
                mem[ram_req.addr] <= ram_req.wdata;
            end else begin
                rdata <= mem[ram_req.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/aud_fe_pkg.sv
/* audio front end shared definitions
   sizes, config and request structs, size and buffer address helpers */

`default_nettype none

package aud_fe_pkg;

    // --------------------------------------------------
    // sizes
    localparam int SAMPLE_W     = 16;
    localparam int MAX_CH       = 2;
    localparam int MAX_FRAME    = 256;        // also block stride in the buffer
    localparam int SBUF_AW      = 10;
    localparam int SIZE_W       = 8;
    localparam int CNT_W        = 12;
    localparam int QBITS_W      = 6;
    localparam int BUS_AW       = 16;
    localparam int BUS_DW       = 32;
    localparam logic [BUS_AW-1:0] DSP_BUF_BASE = 16'h4000;

    // --------------------------------------------------
    // types
    typedef struct packed {
        logic               save_en;
        logic               proc_en;
        logic               ch_mode;         // 0 one channel, 1 two
        logic               proc_ch;         // channel moved to dsp
        logic [SIZE_W-1:0]  frame_code;      // size = (code+1)*16
        logic [SIZE_W-1:0]  fft_code;
        logic [QBITS_W-1:0] quant_bits;
    } aud_cfg_t;

    typedef logic [MAX_CH-1:0][SAMPLE_W-1:0] aud_pair_t;

    typedef struct packed {
        logic               en;
        logic               we;
        logic [SBUF_AW-1:0] addr;
        logic [SAMPLE_W-1:0] wdata;
    } sbuf_req_t;

    typedef struct packed {
        logic              req;
        logic [BUS_AW-1:0] addr;
        logic [BUS_DW-1:0] wdata;
    } bus_req_t;

    // --------------------------------------------------
    // helpers
    function automatic logic [CNT_W-1:0] code_to_size(input logic [SIZE_W-1:0] code);
        logic [CNT_W-1:0] n;
        n = CNT_W'(code) + 1'b1;
        return n << 4;                       // (code+1)*16
    endfunction

    // (blk*MAX_CH + ch)*MAX_FRAME + idx
    function automatic logic [SBUF_AW-1:0] sbuf_addr(input logic blk, input logic ch,
                                                     input logic [CNT_W-1:0] idx);
        int a;
        a = (int'(blk) * MAX_CH + int'(ch)) * MAX_FRAME + int'(idx);
        return SBUF_AW'(a);
    endfunction

endpackage

`default_nettype wire
